/* build.f */
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/inst_rom.sv
logic/branch_predictor.sv
logic/return_stack.sv
logic/fetch_stage.sv
logic/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_assertions.sv
tb/tb_fetch.sv

/* logic/branch_predictor.sv */
////////////////////
// gshare branch predictor
// global history register,
// table of two-bit counters
////////////////////
`timescale 1ns/100ps
`default_nettype none

module branch_predictor (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [fetch_pkg::xlen-1:0] fetch_pc,       // pc being fetched
    input  logic                       update_valid,   // a branch committed
    input  logic                       update_taken,   // its resolved direction
    input  logic [fetch_pkg::xlen-1:0] committed_pc,   // its pc
    output logic                       predict_taken
);
    import fetch_pkg::*;

    logic [bht_iw-1:0] history;                        // newest outcome in bit 0
    ctr_e              bht [0:(2**bht_iw)-1];

    logic [bht_iw-1:0] rd_idx;
    logic [bht_iw-1:0] wr_idx;
    ctr_e              rd_ctr;
    ctr_e              wr_ctr;                         // counter being trained
    ctr_e              wr_ctr_next;

    // both indices hash word address with the same history
    assign rd_idx = fetch_pc[bht_iw+1:2] ^ history;
    assign wr_idx = committed_pc[bht_iw+1:2] ^ history;

    assign rd_ctr = bht[rd_idx];
    assign wr_ctr = bht[wr_idx];

    assign predict_taken = (rd_ctr == weak_t) || (rd_ctr == strong_t);

    // saturating up/down step
    always_comb begin
        wr_ctr_next = wr_ctr;
        if (update_taken) begin
            if (wr_ctr != strong_t) begin
                wr_ctr_next = ctr_e'(wr_ctr + 2'd1);
            end
        end else begin
            if (wr_ctr != strong_nt) begin
                wr_ctr_next = ctr_e'(wr_ctr - 2'd1);
            end
        end
    end

    // training runs whether or not fetch is stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            history <= '0;
            for (int i = 0; i < 2**bht_iw; i++) begin
                bht[i] <= ctr_reset;                   // everything starts weakly not taken
            end
        end else if (update_valid) begin
            bht[wr_idx] <= wr_ctr_next;
            history     <= {history[bht_iw-2:0], update_taken};
        end
    end

endmodule

`default_nettype wire

/* logic/fetch_pkg.sv */
////////////////////
// fetch stage package
// sizes, reset pc, predecode opcodes,
// two-bit counter states, link registers
////////////////////
`default_nettype none

package fetch_pkg;

    localparam int xlen = 32;                       // pc and instruction width
    localparam logic [xlen-1:0] reset_pc = '0;      // first fetch address

    localparam int imem_aw = 8;                     // 256 words of instruction memory

    // gshare predictor
    localparam int bht_iw = 10;                     // index and history width, 1024 counters

    // return address stack
    localparam int ras_depth = 16;
    localparam int ras_pw = 4;                      // log2 of ras_depth

    // major opcodes the predecoder cares about
    typedef enum logic [6:0] {
        op_branch = 7'b1100011,                     // beq, bne, blt, ...
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_other  = 7'b0110011                      // anything else, reported as alu op
    } opcode_e;

    // saturating counter states, msb is the prediction
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_e;

    localparam ctr_e ctr_reset = weak_nt;

    // x1 and x5 act as link registers for the push/pop hints
    localparam logic [4:0] link_ra = 5'd1;
    localparam logic [4:0] link_t0 = 5'd5;

endpackage

`default_nettype wire

/* logic/fetch_stage.sv */
////////////////////
// fetch stage
// predecode, ras push/pop hints,
// next pc selection, fetch bundle
////////////////////
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stall,
    input  logic                         mispredicted,
    input  logic [fetch_pkg::xlen-1:0]   pc_update,
    input  logic [fetch_pkg::ras_pw-1:0] flush_ptr,
    input  logic                         update_valid,
    input  logic                         update_taken,
    input  logic [fetch_pkg::xlen-1:0]   committed_pc,
    input  logic [fetch_pkg::xlen-1:0]   instr,          // word at pc
    output logic [fetch_pkg::xlen-1:0]   pc,             // to instruction memory
    output logic                         fetch_valid,
    output logic [fetch_pkg::xlen-1:0]   fetch_pc,
    output logic [fetch_pkg::xlen-1:0]   fetch_instr,
    output logic                         fetch_pred_taken,
    output logic                         fetch_is_branch,
    output logic                         fetch_is_jump,
    output logic [fetch_pkg::ras_pw-1:0] fetch_ras_ptr,  // ptr before this push/pop
    output logic [fetch_pkg::xlen-1:0]   fetch_target
);
    import fetch_pkg::*;

    opcode_e           opcode;
    logic              is_branch, is_jal, is_jalr;
    logic [4:0]        rd, rs1;
    logic              rd_link, rs1_link;
    logic              push_req, pop_req;
    logic [xlen-1:0]   b_imm, j_imm;
    logic [xlen-1:0]   pc_plus4;
    logic              bp_taken;
    logic [xlen-1:0]   ras_top;
    logic [ras_pw-1:0] ras_ptr;

    pc_gen u_pc_gen (
        .clk, .rst_n, .stall, .mispredicted, .pc_update,
        .next_pc  (fetch_target),
        .pc,
        .pc_valid (fetch_valid)
    );

    branch_predictor u_branch_predictor (
        .clk, .rst_n,
        .fetch_pc      (pc),
        .update_valid, .update_taken, .committed_pc,
        .predict_taken (bp_taken)
    );

    // only a bundle that really leaves the stage moves the stack
    return_stack u_return_stack (
        .clk, .rst_n,
        .push        (push_req & fetch_valid),
        .pop         (pop_req & fetch_valid),
        .push_addr   (pc_plus4),
        .restore     (mispredicted),
        .restore_ptr (flush_ptr),
        .top_addr    (ras_top),
        .ptr         (ras_ptr)
    );

    // predecode, only control flow matters here
    always_comb begin
        case (instr[6:0])
            op_branch: opcode = op_branch;
            op_jal:    opcode = op_jal;
            op_jalr:   opcode = op_jalr;
            default:   opcode = op_other;
        endcase
    end

    assign is_branch = (opcode == op_branch);
    assign is_jal    = (opcode == op_jal);
    assign is_jalr   = (opcode == op_jalr);

    assign rd  = instr[11:7];
    assign rs1 = instr[19:15];

    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign pc_plus4 = pc + 32'd4;

    // risc-v return address hints
    assign rd_link  = (rd == link_ra) || (rd == link_t0);
    assign rs1_link = (rs1 == link_ra) || (rs1 == link_t0);
    assign push_req = (is_jal | is_jalr) & rd_link;          // call
    assign pop_req  = is_jalr & rs1_link & (!rd_link || (rd != rs1)); // return or coroutine

    always_comb begin
        fetch_target = pc_plus4;
        if (is_branch && bp_taken) begin
            fetch_target = pc + b_imm;
        end else if (is_jal) begin
            fetch_target = pc + j_imm;                       // jal target known at fetch
        end else if (pop_req) begin
            fetch_target = ras_top;
        end
    end

    // bundle for the back end
    assign fetch_pc         = pc;
    assign fetch_instr      = instr;
    assign fetch_pred_taken = is_jal | (is_branch & bp_taken) | pop_req;
    assign fetch_is_branch  = is_branch;
    assign fetch_is_jump    = is_jal | is_jalr;
    assign fetch_ras_ptr    = ras_ptr;

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
////////////////////
// fetch top level
// instruction memory and fetch stage
////////////////////
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          mispredicted,
    input  logic [fetch_pkg::xlen-1:0]    pc_update,
    input  logic [fetch_pkg::ras_pw-1:0]  flush_ptr,
    input  logic                          update_valid,
    input  logic                          update_taken,
    input  logic [fetch_pkg::xlen-1:0]    committed_pc,
    input  logic                          imem_we,
    input  logic [fetch_pkg::imem_aw-1:0] imem_addr,
    input  logic [fetch_pkg::xlen-1:0]    imem_wdata,
    output logic                          fetch_valid,
    output logic [fetch_pkg::xlen-1:0]    fetch_pc,
    output logic [fetch_pkg::xlen-1:0]    fetch_instr,
    output logic                          fetch_pred_taken,
    output logic                          fetch_is_branch,
    output logic                          fetch_is_jump,
    output logic [fetch_pkg::ras_pw-1:0]  fetch_ras_ptr,
    output logic [fetch_pkg::xlen-1:0]    fetch_target
);
    import fetch_pkg::*;

    logic [xlen-1:0] pc;       // current fetch address
    logic [xlen-1:0] instr;    // word read at pc

    inst_rom u_inst_rom (
        .clk, .imem_we, .imem_addr, .imem_wdata,
        .rd_addr (pc[imem_aw+1:2]),     // drop byte offset
        .rd_data (instr)
    );

    fetch_stage u_fetch_stage (
        .clk, .rst_n, .stall, .mispredicted, .pc_update, .flush_ptr,
        .update_valid, .update_taken, .committed_pc,
        .instr, .pc,
        .fetch_valid, .fetch_pc, .fetch_instr, .fetch_pred_taken,
        .fetch_is_branch, .fetch_is_jump, .fetch_ras_ptr, .fetch_target
    );

endmodule

`default_nettype wire

/* logic/inst_rom.sv */
////////////////////
// instruction memory
// word array, write port, async read
////////////////////
`timescale 1ns/100ps
`default_nettype none

module inst_rom (
    input  logic                          clk,
    input  logic                          imem_we,
    input  logic [fetch_pkg::imem_aw-1:0] imem_addr,   // word address
    input  logic [fetch_pkg::xlen-1:0]    imem_wdata,
    input  logic [fetch_pkg::imem_aw-1:0] rd_addr,     // pc word address
    output logic [fetch_pkg::xlen-1:0]    rd_data
);
    import fetch_pkg::*;

    logic [xlen-1:0] mem [0:(2**imem_aw)-1];

    // loader writes land at the edge
    always_ff @(posedge clk) begin
        if (imem_we) begin
            mem[imem_addr] <= imem_wdata;
        end
    end

    assign rd_data = mem[rd_addr];                      // same-cycle read for fetch

endmodule

`default_nettype wire

/* logic/pc_gen.sv */
////////////////////
// program counter register
// redirect, stall hold, next pc load
////////////////////
`timescale 1ns/100ps
`default_nettype none

module pc_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,         // back end can't take a bundle
    input  logic                       mispredicted,  // redirect from the back end
    input  logic [fetch_pkg::xlen-1:0] pc_update,     // corrected pc on redirect
    input  logic [fetch_pkg::xlen-1:0] next_pc,       // predicted target from this fetch
    output logic [fetch_pkg::xlen-1:0] pc,
    output logic                       pc_valid
);
    import fetch_pkg::*;

    // redirect beats stall, stall beats the predicted path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (mispredicted) begin
            pc <= pc_update;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

    // bundle only usable when this pc will actually advance
    assign pc_valid = rst_n & ~stall & ~mispredicted;

endmodule

`default_nettype wire

/* logic/return_stack.sv */
////////////////////
// return address stack
// circular, push/pop, checkpoint restore
////////////////////
`timescale 1ns/100ps
`default_nettype none

module return_stack (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  logic                         pop,
    input  logic [fetch_pkg::xlen-1:0]   push_addr,     // return address, pc + 4
    input  logic                         restore,       // back end redirect
    input  logic [fetch_pkg::ras_pw-1:0] restore_ptr,   // checkpointed pointer
    output logic [fetch_pkg::xlen-1:0]   top_addr,
    output logic [fetch_pkg::ras_pw-1:0] ptr
);
    import fetch_pkg::*;

    logic [xlen-1:0]   stack [0:ras_depth-1];
    logic [ras_pw-1:0] top_idx;

    // ptr is the next free slot, top sits just below it
    // wraps naturally so overflow eats the oldest entry
    assign top_idx  = ptr - 1'b1;
    assign top_addr = stack[top_idx];

    // pointer, restore overrides any push or pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (restore) begin
            ptr <= restore_ptr;
        end else if (push && !pop) begin
            ptr <= ptr + 1'b1;
        end else if (pop && !push) begin
            ptr <= ptr - 1'b1;
        end
    end

    // entries, push+pop rewrites the top in place
    always_ff @(posedge clk) begin
        if (push && !restore) begin
            if (pop) begin
                stack[top_idx] <= push_addr;
            end else begin
                stack[ptr] <= push_addr;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/fetch_assertions.sv */
////////////////////
// concurrent assertions on fetch_top ports
// alignment, reset, redirect, stall hold
////////////////////
`timescale 1ns/100ps
`default_nettype none

module fetch_assertions (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       stall,
    input logic                       mispredicted,
    input logic [fetch_pkg::xlen-1:0] pc_update,
    input logic                       fetch_valid,
    input logic [fetch_pkg::xlen-1:0] fetch_pc
);
    int fail_count = 0;    // failed assertions so far

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) fetch_pc[1:0] == 2'b00)
        else begin
            $error("fetch_pc not word aligned");
            fail_count++;
        end

    // nothing leaves the stage while in reset
    valid_in_reset: assert property (@(posedge clk) !rst_n |-> !fetch_valid)
        else begin
            $error("fetch_valid high during reset");
            fail_count++;
        end

    redirect_pc: assert property (@(posedge clk) disable iff (!rst_n)
        mispredicted |=> fetch_pc == $past(pc_update))
        else begin
            $error("fetch_pc did not take pc_update after redirect");
            fail_count++;
        end

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !mispredicted) |=> fetch_pc == $past(fetch_pc))
        else begin
            $error("fetch_pc moved during stall");
            fail_count++;
        end

endmodule

bind fetch_top fetch_assertions u_fetch_assertions (.*);

`default_nettype wire

/* tb/fetch_checker.sv */
////////////////////
// fetch checker
// model of pc, history, counters, stack, memory
// reference function and compare process
////////////////////
`timescale 1ns/100ps
`default_nettype none

module fetch_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          stall,
    input logic                          mispredicted,
    input logic [fetch_pkg::xlen-1:0]    pc_update,
    input logic [fetch_pkg::ras_pw-1:0]  flush_ptr,
    input logic                          update_valid,
    input logic                          update_taken,
    input logic [fetch_pkg::xlen-1:0]    committed_pc,
    input logic                          imem_we,
    input logic [fetch_pkg::imem_aw-1:0] imem_addr,
    input logic [fetch_pkg::xlen-1:0]    imem_wdata,
    input logic                          fetch_valid,
    input logic [fetch_pkg::xlen-1:0]    fetch_pc,
    input logic [fetch_pkg::xlen-1:0]    fetch_instr,
    input logic                          fetch_pred_taken,
    input logic                          fetch_is_branch,
    input logic                          fetch_is_jump,
    input logic [fetch_pkg::ras_pw-1:0]  fetch_ras_ptr,
    input logic [fetch_pkg::xlen-1:0]    fetch_target
);
    import fetch_pkg::*;

    int error_count = 0;
    int check_count = 0;

    // model state, stepped at the falling edge for the rising edge after it
    logic [xlen-1:0]   mem_model [0:(2**imem_aw)-1];   // unwritten words stay x
    logic [1:0]        ctr_model [0:(2**bht_iw)-1];
    logic [bht_iw-1:0] model_hist;                     // newest outcome in bit 0
    logic [xlen-1:0]   ras_model [0:ras_depth-1];
    logic [ras_pw-1:0] model_ptr;                      // next free slot
    logic [xlen-1:0]   model_pc;

    logic [xlen-1:0]   exp_instr;
    logic [xlen-1:0]   exp_target;
    logic              exp_taken, exp_branch, exp_jump, exp_push, exp_pop;
    logic [bht_iw-1:0] upd_idx;

    // expected bundle for a fetch at pc, straight from the isa encodings
    function automatic void ref_bundle(
        input  logic [xlen-1:0] pc,
        output logic [xlen-1:0] instr,
        output logic            taken,
        output logic            is_br,
        output logic            is_jmp,
        output logic            push,
        output logic            pop,
        output logic [xlen-1:0] target
    );
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic            jal;
        logic            jalr;
        logic            rd_lnk;
        logic            rs1_lnk;
        logic            bp;
        logic [xlen-1:0] imm_b;
        logic [xlen-1:0] imm_j;

        instr = mem_model[pc[imem_aw+1:2]];
        rd    = instr[11:7];
        rs1   = instr[19:15];
        is_br = (instr[6:0] == op_branch);
        jal   = (instr[6:0] == op_jal);
        jalr  = (instr[6:0] == op_jalr);
        bp    = ctr_model[pc[bht_iw+1:2] ^ model_hist][1];        // counter msb
        imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        rd_lnk  = (rd == link_ra) || (rd == link_t0);
        rs1_lnk = (rs1 == link_ra) || (rs1 == link_t0);
        push    = (jal || jalr) && rd_lnk;
        pop     = jalr && rs1_lnk && (!rd_lnk || (rd != rs1));
        taken   = jal || (is_br && bp) || pop;
        is_jmp  = jal || jalr;
        if (is_br && bp) begin
            target = pc + imm_b;
        end else if (jal) begin
            target = pc + imm_j;
        end else if (pop) begin
            target = ras_model[model_ptr - 1'b1];                 // top of stack
        end else begin
            target = pc + 32'd4;
        end
    endfunction

    task automatic compare_field(input string name, input logic [xlen-1:0] got,
                                 input logic [xlen-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            model_pc   = reset_pc;
            model_hist = '0;
            model_ptr  = '0;
            for (int i = 0; i < 2**bht_iw; i++) begin
                ctr_model[i] = ctr_reset;
            end
            compare_field("fetch_valid", fetch_valid, 1'b0);
        end else begin
            ref_bundle(model_pc, exp_instr, exp_taken, exp_branch, exp_jump,
                       exp_push, exp_pop, exp_target);
            compare_field("fetch_valid", fetch_valid, !stall && !mispredicted);
            compare_field("fetch_pc", fetch_pc, model_pc);
            compare_field("fetch_ras_ptr", fetch_ras_ptr, model_ptr);
            if (!$isunknown(exp_instr)) begin                     // word already loaded
                compare_field("fetch_instr", fetch_instr, exp_instr);
                compare_field("fetch_pred_taken", fetch_pred_taken, exp_taken);
                compare_field("fetch_is_branch", fetch_is_branch, exp_branch);
                compare_field("fetch_is_jump", fetch_is_jump, exp_jump);
                compare_field("fetch_target", fetch_target, exp_target);
            end
            // training lands at the coming edge, independent of stall
            if (update_valid) begin
                upd_idx = committed_pc[bht_iw+1:2] ^ model_hist;
                if (update_taken && ctr_model[upd_idx] != strong_t) begin
                    ctr_model[upd_idx] = ctr_model[upd_idx] + 2'd1;
                end else if (!update_taken && ctr_model[upd_idx] != strong_nt) begin
                    ctr_model[upd_idx] = ctr_model[upd_idx] - 2'd1;
                end
                model_hist = {model_hist[bht_iw-2:0], update_taken};
            end
            if (mispredicted) begin
                model_pc  = pc_update;
                model_ptr = flush_ptr;                            // checkpoint, no push/pop
            end else if (!stall) begin
                if (exp_push && exp_pop) begin
                    ras_model[model_ptr - 1'b1] = model_pc + 32'd4;
                end else if (exp_push) begin
                    ras_model[model_ptr] = model_pc + 32'd4;
                    model_ptr = model_ptr + 1'b1;
                end else if (exp_pop) begin
                    model_ptr = model_ptr - 1'b1;
                end
                model_pc = exp_target;
            end
        end
        if (imem_we) begin
            mem_model[imem_addr] = imem_wdata;                    // visible after the edge
        end
    end

endmodule

`default_nettype wire

/* tb/tb_fetch.sv */
////////////////////
// testbench for fetch_top
// clock, reset, memory load, sequences,
// timeout and closing line
////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_fetch;
    import fetch_pkg::*;

    logic                clk;
    logic                rst_n;
    logic                stall;
    logic                mispredicted;
    logic [xlen-1:0]     pc_update;
    logic [ras_pw-1:0]   flush_ptr;
    logic                update_valid;
    logic                update_taken;
    logic [xlen-1:0]     committed_pc;
    logic                imem_we;
    logic [imem_aw-1:0]  imem_addr;
    logic [xlen-1:0]     imem_wdata;
    logic                fetch_valid;
    logic [xlen-1:0]     fetch_pc;
    logic [xlen-1:0]     fetch_instr;
    logic                fetch_pred_taken;
    logic                fetch_is_branch;
    logic                fetch_is_jump;
    logic [ras_pw-1:0]   fetch_ras_ptr;
    logic [xlen-1:0]     fetch_target;

    logic [15:0]         lfsr_state = 16'd7760;
    logic [31:0]         r;
    logic [bht_iw-1:0]   ctr_idx;
    logic [bht_iw-1:0]   hist_after;
    logic [xlen-1:0]     alias_pc;
    int                  cycle_count = 0;
    int                  max_cycles = 2000;   // about 2.5x the ~800 cycles below
    int                  total_errors;

    fetch_top u_fetch_top (.*);
    fetch_checker u_fetch_checker (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] program_word(input logic [7:0] w, input logic [31:0] rnd);
        case (w)
            8'd64:   return 32'h020000ef;                 // 0x100 jal x1, +0x20
            8'd66:   return 32'h000080e7;                 // 0x108 jalr x1, 0(x1) pushes only
            8'd73:   return 32'h00008067;                 // 0x124 jalr x0, 0(x1) as return
            8'd128:  return 32'h04000063;                 // 0x200 beq x0, x0, +0x40
            default: return {rnd[16:0], w, 7'b0110011};   // alu op tagged with its address
        endcase
    endfunction

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic redirect(input logic [xlen-1:0] addr, input logic [ras_pw-1:0] ptr);
        @(posedge clk);
        mispredicted <= 1'b1;
        pc_update    <= addr;
        flush_ptr    <= ptr;
        @(posedge clk);
        mispredicted <= 1'b0;
    endtask

    task automatic write_word(input logic [xlen-1:0] byte_addr, input logic [xlen-1:0] data);
        @(posedge clk);
        imem_we    <= 1'b1;
        imem_addr  <= byte_addr[imem_aw+1:2];
        imem_wdata <= data;
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    // n updates aimed at the counter that a fetch of fetch_addr reads afterwards
    task automatic train(input logic [xlen-1:0] fetch_addr, input logic taken, input int n);
        logic [bht_iw-1:0] h;
        logic [bht_iw-1:0] hf;
        h  = u_fetch_checker.model_hist;
        hf = h;
        for (int i = 0; i < n; i++) begin
            hf = {hf[bht_iw-2:0], taken};
        end
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            update_valid <= 1'b1;
            update_taken <= taken;
            committed_pc <= {20'd0, fetch_addr[bht_iw+1:2] ^ hf ^ h, 2'b00};
            h = {h[bht_iw-2:0], taken};
        end
        @(posedge clk);
        update_valid <= 1'b0;
    endtask

    initial begin
        rst_n = 1'b0;
        stall = 1'b1;                                     // hold pc while memory loads
        mispredicted = 1'b0;
        pc_update = '0;
        flush_ptr = '0;
        update_valid = 1'b0;
        update_taken = 1'b0;
        committed_pc = '0;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_wdata = '0;
        run_cycles(10);
        rst_n <= 1'b1;
        for (int w = 0; w < 2**imem_aw; w++) begin
            take_bits(17, r);
            write_word({22'd0, w[7:0], 2'b00}, program_word(w[7:0], r));
        end
        @(posedge clk);
        stall <= 1'b0;
        run_cycles(20);                                   // straight-line fetch from 0
        redirect(32'h100, 4'd0);                          // call, return, jalr x1 x1
        run_cycles(10);
        redirect(32'h200, 4'd0);                          // untrained branch
        run_cycles(3);
        train(32'h200, 1'b1, 2);
        redirect(32'h200, 4'd0);
        run_cycles(3);
        // copy of the branch that reads the same counter after two not-taken updates
        ctr_idx    = 10'h080 ^ u_fetch_checker.model_hist;
        hist_after = {u_fetch_checker.model_hist[bht_iw-3:0], 2'b00};
        alias_pc   = {20'd0, ctr_idx ^ hist_after, 2'b00};
        train(alias_pc, 1'b0, 2);
        write_word(alias_pc, 32'h04000063);
        redirect(alias_pc, 4'd0);
        run_cycles(3);
        redirect(32'h3a0, 4'ha);
        run_cycles(3);
        @(posedge clk);
        stall <= 1'b1;
        redirect(32'h040, 4'h3);                          // redirect wins over stall
        run_cycles(2);
        @(posedge clk);
        stall <= 1'b0;
        run_cycles(3);
        redirect(32'h180, 4'd0);
        for (int i = 0; i < 200; i++) begin               // random stall and training
            @(posedge clk);
            take_bits(1, r);
            stall <= r[0];
            take_bits(2, r);
            update_valid <= r[0];
            update_taken <= r[1];
            take_bits(bht_iw, r);
            committed_pc <= {20'd0, r[bht_iw-1:0], 2'b00};
        end
        @(posedge clk);
        stall <= 1'b0;
        update_valid <= 1'b0;
        run_cycles(5);
        total_errors = u_fetch_checker.error_count + u_fetch_top.u_fetch_assertions.fail_count;
        $display("checks %0d, checker errors %0d, assertion errors %0d, total errors %0d",
                 u_fetch_checker.check_count, u_fetch_checker.error_count,
                 u_fetch_top.u_fetch_assertions.fail_count, total_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: sequences did not finish within %0d cycles", max_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
